/* design/disp_pkg.sv */
`default_nettype none

package disp_pkg;

    // ==================================================
    // widths and format constants
    // ==================================================
    localparam int WORD_W     = 32;
    localparam int DIM_W      = 8;
    localparam int ADDR_W     = 9;
    localparam int COL_WIDTH  = 10;  // digits of the largest word
    localparam int MAX_DIGITS = 10;

    localparam logic [7:0] ASC_SPACE = 8'd32;
    localparam logic [7:0] ASC_CR    = 8'd13;
    localparam logic [7:0] ASC_LF    = 8'd10;
    localparam logic [7:0] ASC_ZERO  = 8'd48;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [DIM_W-1:0]  dim_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // ==================================================
    // commands and requests
    // ==================================================
    typedef enum logic {DISP_MATRIX, DISP_SCALAR} disp_mode_e;

    typedef struct packed {
        disp_mode_e mode;
        dim_t       rows;
        dim_t       cols;
        addr_t      base_addr;
        word_t      scalar;
    } disp_cmd_t;

    typedef enum logic {FMT_NUMBER, FMT_CHAR} fmt_kind_e;

    typedef struct packed {
        fmt_kind_e kind;
        logic      pad_en;  // matrix elements only
        word_t     value;   // low byte is the char for FMT_CHAR
    } fmt_req_t;

    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_ADDR, SEQ_WAIT, SEQ_FETCH, SEQ_NUM, SEQ_SEP, SEQ_DONE
    } seq_state_e;

    typedef enum logic [2:0] {F_IDLE, F_CONV, F_SEND, F_PAD, F_LIT} fmt_state_e;

endpackage

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 217
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        i_start,
    input  wire  [7:0] i_data,
    output logic       o_tx,
    output logic       o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [9:0]       shift_reg;
    logic             bit_end;

    assign bit_end = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign o_tx    = shift_reg[0];  // all ones while idle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt  <= '0;
            bit_idx   <= '0;
            shift_reg <= '1;
            o_busy    <= 1'b0;
        end else if (!o_busy) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            if (i_start) begin
                shift_reg <= {1'b1, i_data, 1'b0};  // stop, data lsb first, start
                o_busy    <= 1'b1;
            end
        end else if (bit_end) begin
            baud_cnt  <= '0;
            shift_reg <= {1'b1, shift_reg[9:1]};
            if (bit_idx == 4'd9) begin
                o_busy <= 1'b0;  // stop bit done
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/dec_formatter.sv */
`default_nettype none

module dec_formatter
    import disp_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire  fmt_req_t i_req,
    input  wire            i_start,
    output logic           o_done,
    input  wire            i_tx_busy,
    output logic [7:0]     o_tx_data,
    output logic           o_tx_start
);

    localparam int PTR_W = $clog2(MAX_DIGITS);
    localparam int CNT_W = $clog2(COL_WIDTH + 1);

    fmt_state_e       state;
    fmt_req_t         req_q;
    word_t            tmp;
    logic [7:0]       dig_buf [MAX_DIGITS];  // ascii digits, lsd at index 0
    logic [PTR_W-1:0] ptr;
    logic [CNT_W-1:0] out_cnt;               // chars sent for this request
    logic             tx_ready;
    logic             issue;
    logic             last_char;
    logic [7:0]       next_char;

    // uart busy rises one cycle late, so block the cycle after a start too
    assign tx_ready = ~i_tx_busy & ~o_tx_start;
    assign issue    = tx_ready && (state == F_SEND || state == F_PAD || state == F_LIT);

    always_comb begin
        next_char = ASC_SPACE;
        last_char = 1'b1;
        case (state)
            F_SEND: begin
                next_char = dig_buf[ptr];
                last_char = (ptr == '0) &&
                            !(req_q.pad_en && out_cnt < CNT_W'(COL_WIDTH - 1));
            end
            F_PAD:   last_char = (out_cnt == CNT_W'(COL_WIDTH - 1));
            F_LIT:   next_char = req_q.value[7:0];
            default: last_char = 1'b0;
        endcase
    end

    // ==================================================
    // control
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= F_IDLE;
            ptr        <= '0;
            out_cnt    <= '0;
            o_tx_start <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_tx_start <= issue;
            o_done     <= issue && last_char;  // same cycle as the last tx_start
            case (state)
                F_IDLE: begin
                    if (i_start) begin
                        ptr     <= '0;
                        out_cnt <= '0;
                        state   <= (i_req.kind == FMT_CHAR) ? F_LIT : F_CONV;
                    end
                end
                F_CONV: begin
                    if (tmp >= WORD_W'(10)) begin
                        ptr <= ptr + 1'b1;
                    end else begin
                        state <= F_SEND;  // ptr sits on the msd
                    end
                end
                default: begin
                    if (issue) begin
                        out_cnt <= out_cnt + 1'b1;
                        if (state == F_SEND && ptr != '0) begin
                            ptr <= ptr - 1'b1;
                        end
                        if (last_char) begin
                            state <= F_IDLE;
                        end else if (state == F_SEND && ptr == '0) begin
                            state <= F_PAD;
                        end
                    end
                end
            endcase
        end
    end

    // ==================================================
    // datapath
    // ==================================================
    always_ff @(posedge clk) begin
        if (state == F_IDLE && i_start) begin
            req_q <= i_req;
            tmp   <= i_req.value;
        end
        if (state == F_CONV) begin
            dig_buf[ptr] <= ASC_ZERO + 8'(tmp % WORD_W'(10));
            if (tmp >= WORD_W'(10)) begin
                tmp <= tmp / WORD_W'(10);
            end
        end
        if (issue) begin
            o_tx_data <= next_char;
        end
    end

endmodule

`default_nettype wire

/* design/matrix_sequencer.sv */
`default_nettype none

module matrix_sequencer
    import disp_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             i_en_display,
    input  wire  disp_cmd_t i_cmd,
    output addr_t           o_rd_addr,
    input  wire  word_t     i_rd_data,
    output fmt_req_t        o_fmt_req,
    output logic            o_fmt_start,
    input  wire             i_fmt_done,
    output logic            o_done
);

    seq_state_e state;
    disp_cmd_t  cmd_q;
    dim_t       row;
    dim_t       col;
    addr_t      row_addr;   // base_addr + row * cols, wraps at 512
    logic       crlf_step;  // 0 sends CR, 1 sends LF
    logic       pend;       // request issued, waiting for done
    word_t      num_q;
    logic       last_col;
    logic       last_row;
    logic       req_state;
    logic       fmt_ack;
    logic [7:0] sep_char;

    // scalar mode behaves like a single last column of the last row
    assign last_col  = (cmd_q.mode == DISP_SCALAR) || (col == cmd_q.cols - 1'b1);
    assign last_row  = (cmd_q.mode == DISP_SCALAR) || (row == cmd_q.rows - 1'b1);
    assign req_state = (state == SEQ_NUM) || (state == SEQ_SEP);
    assign fmt_ack   = pend && i_fmt_done;
    assign o_done    = (state == SEQ_DONE);

    always_comb begin
        if (!last_col) begin
            sep_char = ASC_SPACE;
        end else begin
            sep_char = crlf_step ? ASC_LF : ASC_CR;
        end
    end

    always_comb begin
        o_fmt_req.kind   = FMT_NUMBER;
        o_fmt_req.pad_en = (cmd_q.mode == DISP_MATRIX);
        o_fmt_req.value  = (cmd_q.mode == DISP_SCALAR) ? cmd_q.scalar : num_q;
        if (state == SEQ_SEP) begin
            o_fmt_req.kind   = FMT_CHAR;
            o_fmt_req.pad_en = 1'b0;
            o_fmt_req.value  = WORD_W'(sep_char);
        end
    end

    // ==================================================
    // walk FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SEQ_IDLE;
            cmd_q       <= '0;
            row         <= '0;
            col         <= '0;
            row_addr    <= '0;
            o_rd_addr   <= '0;
            crlf_step   <= 1'b0;
            pend        <= 1'b0;
            o_fmt_start <= 1'b0;
        end else begin
            o_fmt_start <= 1'b0;
            if (req_state && !pend) begin
                o_fmt_start <= 1'b1;
                pend        <= 1'b1;
            end
            if (fmt_ack) begin
                pend <= 1'b0;
            end

            case (state)
                SEQ_IDLE: begin
                    if (i_en_display) begin
                        cmd_q     <= i_cmd;
                        row       <= '0;
                        col       <= '0;
                        crlf_step <= 1'b0;
                        pend      <= 1'b0;
                        row_addr  <= i_cmd.base_addr;
                        if (i_cmd.mode == DISP_SCALAR) begin
                            state <= SEQ_NUM;
                        end else if (i_cmd.rows == '0 || i_cmd.cols == '0) begin
                            state <= SEQ_DONE;  // nothing to print
                        end else begin
                            state <= SEQ_ADDR;
                        end
                    end
                end
                SEQ_ADDR: begin
                    o_rd_addr <= row_addr + addr_t'(col);
                    state     <= SEQ_WAIT;
                end
                SEQ_WAIT:  state <= SEQ_FETCH;  // storage read latency
                SEQ_FETCH: state <= SEQ_NUM;
                SEQ_NUM: begin
                    if (fmt_ack) begin
                        state <= SEQ_SEP;
                    end
                end
                SEQ_SEP: begin
                    if (fmt_ack) begin
                        if (!last_col) begin
                            col   <= col + 1'b1;
                            state <= SEQ_ADDR;
                        end else if (!crlf_step) begin
                            crlf_step <= 1'b1;  // LF next
                        end else begin
                            crlf_step <= 1'b0;
                            col       <= '0;
                            if (last_row) begin
                                state <= SEQ_DONE;
                            end else begin
                                row      <= row + 1'b1;
                                row_addr <= row_addr + addr_t'(cmd_q.cols);
                                state    <= SEQ_ADDR;
                            end
                        end
                    end
                end
                SEQ_DONE: begin
                    if (!i_en_display) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_FETCH) begin
            num_q <= i_rd_data;
        end
    end

endmodule

`default_nettype wire

/* design/matrix_display.sv */
`default_nettype none

module matrix_display
    import disp_pkg::*;
#(
    parameter int CLKS_PER_BIT = 217  // 25 MHz at 115200 baud
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             i_en_display,
    input  wire  disp_cmd_t i_cmd,
    output addr_t           o_rd_addr,
    input  wire  word_t     i_rd_data,
    output logic            o_tx,
    output logic            o_done
);

    fmt_req_t   fmt_req;
    logic       fmt_start;
    logic       fmt_done;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    matrix_sequencer u_matrix_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_en_display (i_en_display),
        .i_cmd        (i_cmd),
        .o_rd_addr    (o_rd_addr),
        .i_rd_data    (i_rd_data),
        .o_fmt_req    (fmt_req),
        .o_fmt_start  (fmt_start),
        .i_fmt_done   (fmt_done),
        .o_done       (o_done)
    );

    dec_formatter u_dec_formatter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (fmt_req),
        .i_start    (fmt_start),
        .o_done     (fmt_done),
        .i_tx_busy  (tx_busy),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_tx    (o_tx),
        .o_busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* testbench/tb_uart_rx.sv */
`default_nettype none

module tb_uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        i_rx,
    output logic       o_valid,
    output logic [7:0] o_byte,
    output logic       o_frame_err
);

    timeunit 1ns;
    timeprecision 100ps;

    int         cnt;     // clocks since the start edge
    int         bit_no;  // 0 start, 1..8 data, 9 stop
    logic       busy;
    logic [7:0] sh;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            cnt         <= 0;
            bit_no      <= 0;
            sh          <= '0;
            o_valid     <= 1'b0;
            o_byte      <= '0;
            o_frame_err <= 1'b0;
        end else begin
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
            if (!busy) begin
                if (!i_rx) begin
                    busy   <= 1'b1;  // falling edge of a start bit
                    cnt    <= 1;
                    bit_no <= 0;
                end
            end else begin
                cnt <= cnt + 1;
                // sample at the centre of each bit
                if (cnt == CLKS_PER_BIT / 2 + bit_no * CLKS_PER_BIT) begin
                    bit_no <= bit_no + 1;
                    if (bit_no == 0 && i_rx) begin
                        busy <= 1'b0;  // glitch, not a start bit
                    end else if (bit_no >= 1 && bit_no <= 8) begin
                        sh <= {i_rx, sh[7:1]};  // lsb first
                    end else if (bit_no == 9) begin
                        busy        <= 1'b0;
                        o_valid     <= i_rx;
                        o_byte      <= sh;
                        o_frame_err <= !i_rx;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_matrix_display.sv */
`default_nettype none

module tb_matrix_display
    import disp_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT = 8;

    logic       clk;
    logic       rst_n;
    logic       en;
    disp_cmd_t  cmd;
    addr_t      rd_addr;
    word_t      rd_data = '0;
    logic       tx;
    logic       done;
    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       rx_ferr;

    logic [31:0] mem [512];  // storage model
    logic [7:0]  exp_q [$];
    logic [7:0]  rx_q [$];
    int          seed;
    int          errors;
    int          tests;
    int          failed_tests;
    time         deadline;

    matrix_display #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_matrix_display (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_en_display (en),
        .i_cmd        (cmd),
        .o_rd_addr    (rd_addr),
        .i_rd_data    (rd_data),
        .o_tx         (tx),
        .o_done       (done)
    );

    tb_uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_rx        (tx),
        .o_valid     (rx_valid),
        .o_byte      (rx_byte),
        .o_frame_err (rx_ferr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        rd_data <= mem[rd_addr];  // registered read
    end

    always @(posedge clk) begin
        if (rx_valid) begin
            rx_q.push_back(rx_byte);
        end
        if (rx_ferr) begin
            errors++;
            $display("t=%0t: serial frame received with a low stop bit", $time);
        end
    end

    // ==================================================
    // watchdog
    // ==================================================
    initial begin
        deadline = 64'd2000;
        while ($time <= deadline) @(posedge clk);
        $display("t=%0t: timeout, the DUT stopped responding", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        int          sh;
        w  = $random(seed);
        sh = $random(seed) & 31;  // vary the digit count
        return w >> sh;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic push_dec(input logic [31:0] v, input logic pad);
        string s;
        s = $sformatf("%0d", v);
        for (int i = 0; i < s.len(); i++) begin
            exp_q.push_back(s[i]);
        end
        if (pad) begin
            for (int k = s.len(); k < 10; k++) begin
                exp_q.push_back(8'd32);
            end
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================
    task automatic build_expected(input disp_cmd_t c);
        int a;
        exp_q.delete();
        if (c.mode == DISP_SCALAR) begin
            push_dec(c.scalar, 1'b0);
            exp_q.push_back(8'd13);
            exp_q.push_back(8'd10);
        end else begin
            for (int r = 0; r < int'(c.rows); r++) begin
                for (int col = 0; col < int'(c.cols); col++) begin
                    a = (int'(c.base_addr) + r * int'(c.cols) + col) % 512;
                    push_dec(mem[a[8:0]], 1'b1);
                    if (col < int'(c.cols) - 1) begin
                        exp_q.push_back(8'd32);
                    end else begin
                        exp_q.push_back(8'd13);
                        exp_q.push_back(8'd10);
                    end
                end
            end
        end
    endtask

    task automatic run_cmd(input disp_cmd_t c, input string name, input int hold);
        int e0;
        int n;
        e0 = errors;
        build_expected(c);
        rx_q.delete();
        deadline = $time + 64'(exp_q.size() * 10 * CLKS_PER_BIT * 10 * 2 + 5000);
        @(posedge clk);
        #1;
        cmd = c;
        en  = 1'b1;
        @(negedge clk);
        while (!done) @(negedge clk);
        repeat (11 * CLKS_PER_BIT) @(negedge clk);  // last frame still on the line
        repeat (hold) begin
            check_val("o_done", 32'(done), 32'd1);
            @(negedge clk);
        end
        check_val("o_done", 32'(done), 32'd1);
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            if (rx_q[i] !== exp_q[i]) begin
                errors++;
                $display("CHECK FAILED t=%0t o_tx char %0d got 0x%02h expected 0x%02h",
                         $time, i, rx_q[i], exp_q[i]);
            end
        end
        if (rx_q.size() != exp_q.size()) begin
            errors++;
            $display("t=%0t: %s received %0d characters but %0d were expected",
                     $time, name, rx_q.size(), exp_q.size());
        end
        @(posedge clk);
        #1;
        en = 1'b0;
        @(negedge clk);
        n = 0;
        while (done && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (done) begin
            errors++;
            $display("t=%0t: o_done stayed high after the enable dropped", $time);
        end
        tests++;
        if (errors != e0) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        disp_cmd_t c;
        seed         = 32'h112780b0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        rst_n        = 1'b0;
        en           = 1'b0;
        cmd          = '0;
        for (int i = 0; i < 512; i++) begin
            mem[i] = rand_word();
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check_val("o_tx", 32'(tx), 32'd1);
        check_val("o_done", 32'(done), 32'd0);
        check_val("o_rd_addr", 32'(rd_addr), 32'd0);
        tests++;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test reset: %s", (errors != 0) ? "failed" : "ok");

        for (int i = 0; i < 12; i++) begin
            c        = '0;
            c.mode   = DISP_SCALAR;
            c.scalar = (i == 0) ? 32'd0 : (i == 1) ? 32'd9 : (i == 2) ? 32'd10 :
                       (i == 3) ? 32'hffff_ffff : rand_word();
            run_cmd(c, $sformatf("scalar %0d", c.scalar), 0);
        end

        for (int i = 0; i < 6; i++) begin
            c           = '0;
            c.mode      = DISP_MATRIX;
            c.rows      = 8'(1 + ($random(seed) & 255) % 5);
            c.cols      = 8'(1 + ($random(seed) & 255) % 5);
            c.base_addr = 9'($random(seed) & 511);
            run_cmd(c, $sformatf("matrix %0dx%0d at %0d", c.rows, c.cols, c.base_addr), 0);
        end

        // ten digit element needs no padding
        mem[77]     = 32'd4000000000;
        c           = '0;
        c.mode      = DISP_MATRIX;
        c.rows      = 8'd1;
        c.cols      = 8'd1;
        c.base_addr = 9'd77;
        run_cmd(c, "matrix 1x1 full width", 0);

        c.rows      = 8'd3;
        c.cols      = 8'd4;
        c.base_addr = 9'd509;  // addresses wrap past 511
        run_cmd(c, "matrix 3x4 address wrap", 0);

        // done held with the enable and a second command straight after
        c.rows      = 8'd2;
        c.cols      = 8'd3;
        c.base_addr = 9'd200;
        run_cmd(c, "done hold", 50);
        c        = '0;
        c.mode   = DISP_SCALAR;
        c.scalar = 32'd123456;
        run_cmd(c, "command after done", 0);

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests, failed_tests, errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/disp_pkg.sv
design/uart_tx.sv
design/dec_formatter.sv
design/matrix_sequencer.sv
design/matrix_display.sv
testbench/tb_uart_rx.sv
testbench/tb_matrix_display.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matrix display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f project.f \
    --top-module tb_matrix_display -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_matrix_display)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
